// File: cdc_src.sv
/*
 * Source half of a gray-pointer asynchronous FIFO
 * Flat storage and write pointer out, read pointer in through two flops
 */

`timescale 1ns/1ps

module cdc_src
   import secsub_pkg::*;
#(
   parameter int unsigned LogDepth = 2
) (
   input  logic                                         clk_i,
   input  logic                                         rst_n_i,
   input  logic                                         push_i,
   input  rng_word_t                                    push_word_i,
   output logic                                         full_o,
   output logic [$bits(rng_word_t)*(2**LogDepth)-1:0]   async_data_o,
   output logic [LogDepth:0]                            async_wptr_o,
   input  logic [LogDepth:0]                            async_rptr_i
);

   localparam int unsigned Depth = 2 ** LogDepth;
   localparam int unsigned WordW = $bits(rng_word_t);

   typedef logic [LogDepth:0] ptr_t;

   // Gray pointers one lap apart differ in the top two bits only
   localparam ptr_t FullMask = ptr_t'(3 << (LogDepth - 1));

   rng_word_t mem_q [Depth];
   ptr_t      wptr_bin_q;
   ptr_t      wptr_gray_q;
   ptr_t      wptr_bin_next;
   ptr_t      rptr_meta_q;
   ptr_t      rptr_sync_q;
   logic      do_push;

   assign do_push       = push_i && !full_o;
   assign wptr_bin_next = wptr_bin_q + ptr_t'(1);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wptr_bin_q  <= '0;
         wptr_gray_q <= '0;
      end else if (do_push) begin
         wptr_bin_q  <= wptr_bin_next;
         wptr_gray_q <= wptr_bin_next ^ (wptr_bin_next >> 1);
      end
   end

   // Storage slots, written at the binary write pointer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int k = 0; k < Depth; k++) begin
            mem_q[k] <= '0;
         end
      end else if (do_push) begin
         mem_q[wptr_bin_q[LogDepth-1:0]] <= push_word_i;
      end
   end

   // Read pointer from the foreign domain
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rptr_meta_q <= '0;
         rptr_sync_q <= '0;
      end else begin
         rptr_meta_q <= async_rptr_i;
         rptr_sync_q <= rptr_meta_q;
      end
   end

   assign full_o = ((wptr_gray_q ^ rptr_sync_q) == FullMask);

   for (genvar k = 0; k < Depth; k++) begin : g_flat
      assign async_data_o[k*WordW +: WordW] = mem_q[k];
   end

   assign async_wptr_o = wptr_gray_q;

endmodule

// File: entropy_cell.sv
/*
 * Single LFSR noise stream with a per-stream seed offset
 */

`timescale 1ns/1ps

module entropy_cell
   import secsub_pkg::*;
#(
   parameter int unsigned StreamIdx = 0
) (
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  load_i,
   input  lfsr_t seed_i,
   input  logic  step_i,
   output logic  bit_o
);

   lfsr_t state_q;

   // Stream offset keeps the cells apart when they share one seed
   function automatic lfsr_t mix_seed(lfsr_t seed);
      lfsr_t mixed;
      mixed = seed ^ lfsr_t'(StreamIdx + 1);
      if (mixed == '0) begin
         mixed = SeedZeroSub;
      end
      return mixed;
   endfunction

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= mix_seed('0);
      end else if (load_i) begin
         state_q <= mix_seed(seed_i);
      end else if (step_i) begin
         state_q <= (state_q >> 1) ^ (state_q[0] ? LfsrMask : lfsr_t'(0));
      end
   end

   assign bit_o = state_q[0];

endmodule

// File: files.f
secsub_pkg.sv
rst_sync.sv
entropy_cell.sv
rng_ctrl.sv
word_packer.sv
cdc_src.sv
secsub_top.sv
secsub_checker.sv
tb_secsub.sv

// File: rng_ctrl.sv
/*
 * Wishbone classic register slave: enable, seed load and status counters
 */

`timescale 1ns/1ps

module rng_ctrl
   import secsub_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   // Wishbone classic slave
   input  logic      wb_cyc_i,
   input  logic      wb_stb_i,
   input  logic      wb_we_i,
   input  wb_addr_t  wb_adr_i,
   input  rng_word_t wb_dat_i,
   output rng_word_t wb_dat_o,
   output logic      wb_ack_o,
   // Datapath status and control
   input  logic      word_push_i,
   input  logic      fifo_full_i,
   output logic      enable_o,
   output logic      seed_load_o,
   output lfsr_t     seed_o
);

   wb_state_e   state_q;
   wb_state_e   state_d;
   logic        enable_q;
   lfsr_t       seed_q;
   logic        seed_load_q;
   logic [15:0] push_count_q;
   logic        wr_ack;
   rng_word_t   rdata;

   assign wb_ack_o = (state_q == WB_ACK);

   // Master holds address and data until it sees ack
   assign wr_ack = wb_ack_o && wb_we_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         WB_IDLE: begin
            if (wb_cyc_i && wb_stb_i) begin
               state_d = WB_ACK;
            end
         end
         WB_ACK: begin
            state_d = WB_IDLE;
         end
         default: begin
            state_d = WB_IDLE;
         end
      endcase
   end

   // Read mux, unknown offsets read as zero
   always_comb begin
      rdata = '0;
      case (wb_adr_i)
         RegCtrl:   rdata[0] = enable_q;
         RegSeed:   rdata[15:0] = seed_q;
         RegStatus: rdata = {15'd0, fifo_full_i, push_count_q};
         default:   rdata = '0;
      endcase
   end

   assign wb_dat_o = (wb_ack_o && !wb_we_i) ? rdata : '0;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= WB_IDLE;
         enable_q     <= 1'b0;
         seed_q       <= '0;
         seed_load_q  <= 1'b0;
         push_count_q <= '0;
      end else begin
         state_q     <= state_d;
         // Load pulse lands in the cycle after the seed write ack
         seed_load_q <= wr_ack && (wb_adr_i == RegSeed);
         if (wr_ack && (wb_adr_i == RegCtrl)) begin
            enable_q <= wb_dat_i[0];
         end
         if (wr_ack && (wb_adr_i == RegSeed)) begin
            seed_q <= wb_dat_i[15:0];
         end
         if (word_push_i) begin
            push_count_q <= push_count_q + 16'd1;
         end
      end
   end

   assign enable_o    = enable_q;
   assign seed_load_o = seed_load_q;
   assign seed_o      = seed_q;

endmodule

// File: rst_sync.sv
/*
 * Reset generator, asserts asynchronously and releases after two clock edges
 */

`timescale 1ns/1ps

module rst_sync (
   input  logic clk_i,
   input  logic rst_n_i,
   output logic rst_n_o
);

   logic [1:0] sync_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], 1'b1};
      end
   end

   assign rst_n_o = sync_q[1];

endmodule

// File: run.sh
#!/bin/sh
# Build and run the secure subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f files.f \
   --top-module tb_secsub \
   -Mdir obj_dir -o sim_secsub

./obj_dir/sim_secsub | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
   exit 0
else
   echo "Simulation did not pass, see sim.log"
   exit 1
fi

// File: secsub_checker.sv
/*
 * Concurrent assertions on the Wishbone ack and the outbound write pointer,
 * bound into the subsystem top level
 */

`timescale 1ns/1ps

module secsub_checker #(
   parameter int unsigned LogDepth = 2
) (
   input logic              clk_i,
   input logic              rst_n_i,
   input logic              wb_cyc_i,
   input logic              wb_stb_i,
   input logic              wb_ack_i,
   input logic [LogDepth:0] wptr_i
);

   // Ack only answers a request seen on the previous edge
   ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
      else $error("wb_ack_o rose without cyc and stb in the previous cycle");

   ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb_ack_i |=> !wb_ack_i)
      else $error("wb_ack_o stayed high for two cycles");

   // Gray code, so at most one bit may flip per edge
   wptr_one_bit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $countones(wptr_i ^ $past(wptr_i)) <= 1)
      else $error("async_wptr_o changed in more than one bit");

endmodule

bind secsub_top secsub_checker #(
   .LogDepth ( LogDepth )
) i_checker (
   .clk_i    ( clk_i        ),
   .rst_n_i  ( rst_n_i      ),
   .wb_cyc_i ( wb_cyc_i     ),
   .wb_stb_i ( wb_stb_i     ),
   .wb_ack_i ( wb_ack_o     ),
   .wptr_i   ( async_wptr_o )
);

// File: secsub_pkg.sv
/*
 * Shared types, register map, LFSR constants and Wishbone slave states
 */

package secsub_pkg;

   // One packed entropy word, also the Wishbone data width
   typedef logic [31:0] rng_word_t;

   // State and seed of a single noise stream
   typedef logic [15:0] lfsr_t;

   // Byte address inside the register window
   typedef logic [3:0] wb_addr_t;

   // Register offsets
   localparam wb_addr_t RegCtrl   = 4'h0;
   localparam wb_addr_t RegSeed   = 4'h4;
   localparam wb_addr_t RegStatus = 4'h8;

   // Galois feedback taps, right shifting
   localparam lfsr_t LfsrMask = 16'hB400;

   // Used whenever a cell would end up with an all-zero state
   localparam lfsr_t SeedZeroSub = 16'hACE1;

   typedef enum logic {
      WB_IDLE,
      WB_ACK
   } wb_state_e;

endpackage

// File: secsub_top.sv
/*
 * Secure subsystem slice: reset, register slave, entropy cells,
 * word packer and CDC source
 */

`timescale 1ns/1ps

module secsub_top
   import secsub_pkg::*;
#(
   parameter int unsigned NumStreams = 4,
   parameter int unsigned LogDepth   = 2
) (
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,
   // Wishbone register port
   input  logic                                       wb_cyc_i,
   input  logic                                       wb_stb_i,
   input  logic                                       wb_we_i,
   input  wb_addr_t                                   wb_adr_i,
   input  rng_word_t                                  wb_dat_i,
   output rng_word_t                                  wb_dat_o,
   output logic                                       wb_ack_o,
   // Asynchronous FIFO port
   output logic [$bits(rng_word_t)*(2**LogDepth)-1:0] async_data_o,
   output logic [LogDepth:0]                          async_wptr_o,
   input  logic [LogDepth:0]                          async_rptr_i
);

   logic                  sys_rst_n;
   logic                  rng_enable;
   logic                  seed_load;
   lfsr_t                 seed_val;
   logic [NumStreams-1:0] cell_bits;
   logic                  cell_step;
   logic                  word_push;
   rng_word_t             push_word;
   logic                  fifo_full;

   rst_sync i_rst_sync (
      .clk_i   ( clk_i     ),
      .rst_n_i ( rst_n_i   ),
      .rst_n_o ( sys_rst_n )
   );

   rng_ctrl i_rng_ctrl (
      .clk_i       ( clk_i      ),
      .rst_n_i     ( sys_rst_n  ),
      .wb_cyc_i    ( wb_cyc_i   ),
      .wb_stb_i    ( wb_stb_i   ),
      .wb_we_i     ( wb_we_i    ),
      .wb_adr_i    ( wb_adr_i   ),
      .wb_dat_i    ( wb_dat_i   ),
      .wb_dat_o    ( wb_dat_o   ),
      .wb_ack_o    ( wb_ack_o   ),
      .word_push_i ( word_push  ),
      .fifo_full_i ( fifo_full  ),
      .enable_o    ( rng_enable ),
      .seed_load_o ( seed_load  ),
      .seed_o      ( seed_val   )
   );

   for (genvar i = 0; i < NumStreams; i++) begin : g_cells
      entropy_cell #(
         .StreamIdx ( i )
      ) i_cell (
         .clk_i   ( clk_i        ),
         .rst_n_i ( sys_rst_n    ),
         .load_i  ( seed_load    ),
         .seed_i  ( seed_val     ),
         .step_i  ( cell_step    ),
         .bit_o   ( cell_bits[i] )
      );
   end

   word_packer #(
      .NumStreams ( NumStreams )
   ) i_word_packer (
      .clk_i       ( clk_i      ),
      .rst_n_i     ( sys_rst_n  ),
      .enable_i    ( rng_enable ),
      .restart_i   ( seed_load  ),
      .bits_i      ( cell_bits  ),
      .full_i      ( fifo_full  ),
      .step_o      ( cell_step  ),
      .push_o      ( word_push  ),
      .push_word_o ( push_word  )
   );

   cdc_src #(
      .LogDepth ( LogDepth )
   ) i_cdc_src (
      .clk_i        ( clk_i        ),
      .rst_n_i      ( sys_rst_n    ),
      .push_i       ( word_push    ),
      .push_word_i  ( push_word    ),
      .full_o       ( fifo_full    ),
      .async_data_o ( async_data_o ),
      .async_wptr_o ( async_wptr_o ),
      .async_rptr_i ( async_rptr_i )
   );

endmodule

// File: tb_secsub.sv
/*
 * Testbench: Wishbone master, FIFO destination reader, LFSR stream model
 * and directed tests for the secure subsystem slice
 */

`timescale 1ns/1ps

module tb_secsub
   import secsub_pkg::*;
();

   localparam int unsigned NumStreams = 4;
   localparam int unsigned LogDepth   = 2;
   localparam int unsigned Depth      = 2 ** LogDepth;
   localparam int unsigned WordW      = 32;
   localparam int unsigned ClkPeriod  = 40;
   localparam int unsigned DriveDly   = 2;
   localparam int unsigned RandSeed   = 32'hc48e_916e;
   // Tests take about 600 cycles
   localparam int unsigned TestCycles = 600;
   localparam int unsigned MaxCycles  = TestCycles * 6 + 400;

   typedef logic [LogDepth:0] ptr_t;

   logic                  clk;
   logic                  rst_n;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   wb_addr_t              wb_adr;
   rng_word_t             wb_wdata;
   rng_word_t             wb_rdata;
   logic                  wb_ack;
   logic [WordW*Depth-1:0] async_data;
   ptr_t                  async_wptr;
   ptr_t                  async_rptr;

   ptr_t        rd_ptr;
   lfsr_t       model_state [NumStreams];
   lfsr_t       cur_seed;
   int unsigned cycle_count = 0;
   int          check_count = 0;
   int          err_count = 0;

   secsub_top #(
      .NumStreams ( NumStreams ),
      .LogDepth   ( LogDepth   )
   ) dut (
      .clk_i        ( clk        ),
      .rst_n_i      ( rst_n      ),
      .wb_cyc_i     ( wb_cyc     ),
      .wb_stb_i     ( wb_stb     ),
      .wb_we_i      ( wb_we      ),
      .wb_adr_i     ( wb_adr     ),
      .wb_dat_i     ( wb_wdata   ),
      .wb_dat_o     ( wb_rdata   ),
      .wb_ack_o     ( wb_ack     ),
      .async_data_o ( async_data ),
      .async_wptr_o ( async_wptr ),
      .async_rptr_i ( async_rptr )
   );

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MaxCycles) begin
         $display("Timeout: run exceeded %0d cycles, the DUT stopped answering", MaxCycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #(DriveDly);
   endtask

   task automatic wb_write(input wb_addr_t adr, input rng_word_t data);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_wdata = data;
      next_cycle();
      while (!wb_ack) begin
         next_cycle();
      end
      // Address and data stay valid through the ack cycle
      next_cycle();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(input wb_addr_t adr, output rng_word_t data);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      next_cycle();
      while (!wb_ack) begin
         next_cycle();
      end
      data = wb_rdata;
      next_cycle();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   function automatic ptr_t gray_to_bin(ptr_t gray);
      ptr_t bin;
      bin[LogDepth] = gray[LogDepth];
      for (int i = LogDepth - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // Destination side of the FIFO
   task automatic pop_word(output rng_word_t word);
      int slot;
      while (gray_to_bin(async_wptr) == rd_ptr) begin
         next_cycle();
      end
      slot       = int'(rd_ptr[LogDepth-1:0]);
      word       = async_data[slot*WordW +: WordW];
      rd_ptr     = rd_ptr + ptr_t'(1);
      async_rptr = rd_ptr ^ (rd_ptr >> 1);
      next_cycle();
   endtask

   function automatic lfsr_t cell_seed(lfsr_t seed, int idx);
      lfsr_t s;
      s = seed ^ lfsr_t'(idx + 1);
      if (s == 16'h0000) begin
         s = SeedZeroSub;
      end
      return s;
   endfunction

   task automatic model_load(input lfsr_t seed);
      for (int i = 0; i < NumStreams; i++) begin
         model_state[i] = cell_seed(seed, i);
      end
   endtask

   // One nibble per step, cell i gives bit i, lowest slot first
   task automatic model_next_word(output rng_word_t word);
      int    slot;
      int    i;
      lfsr_t s;
      for (slot = 0; slot < WordW / NumStreams; slot++) begin
         for (i = 0; i < NumStreams; i++) begin
            s = model_state[i];
            word[slot*NumStreams + i] = s[0];
            model_state[i] = (s >> 1) ^ (s[0] ? LfsrMask : 16'h0000);
         end
      end
   endtask

   task automatic check_word(input string what, input rng_word_t got, input rng_word_t exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic check_seed(input string what, input lfsr_t got, input lfsr_t exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %04h, expected %04h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         $display("%s: done, no errors", name);
      end else begin
         $display("%s: done, %0d errors", name, err_count - errs_before);
      end
   endtask

   task automatic test_reset();
      int        errs;
      rng_word_t got;
      errs = err_count;
      check_bit("write pointer at zero", async_wptr == '0, 1'b1);
      for (int k = 0; k < Depth; k++) begin
         check_word($sformatf("FIFO slot %0d", k), async_data[k*WordW +: WordW], '0);
      end
      wb_read(RegCtrl, got);
      check_word("CTRL after reset", got, '0);
      wb_read(RegSeed, got);
      check_seed("SEED after reset", got[15:0], 16'h0000);
      wb_read(RegStatus, got);
      check_word("STATUS after reset", got, '0);
      report_test("reset state", errs);
   endtask

   task automatic test_registers();
      int        errs;
      rng_word_t got;
      errs = err_count;
      wb_write(RegSeed, 32'h0000_5a3c);
      wb_read(RegSeed, got);
      check_seed("SEED readback", got[15:0], 16'h5a3c);
      // Short enable, too few steps to finish a word
      wb_write(RegCtrl, 32'h1);
      wb_read(RegCtrl, got);
      check_bit("CTRL enable readback", got[0], 1'b1);
      wb_write(RegCtrl, 32'h0);
      wb_read(RegCtrl, got);
      check_bit("CTRL disable readback", got[0], 1'b0);
      // Unmapped offset, still acked
      wb_read(4'hc, got);
      check_word("unmapped register", got, '0);
      report_test("register access", errs);
   endtask

   task automatic test_stream();
      int        errs;
      rng_word_t got;
      rng_word_t exp;
      errs = err_count;
      cur_seed = lfsr_t'($urandom);
      wb_write(RegSeed, rng_word_t'(cur_seed));
      model_load(cur_seed);
      wb_write(RegCtrl, 32'h1);
      for (int n = 0; n < 6; n++) begin
         pop_word(got);
         model_next_word(exp);
         check_word($sformatf("stream word %0d", n), got, exp);
      end
      // Stop the producer before the seventh word completes
      wb_write(RegCtrl, 32'h0);
      wb_read(RegStatus, got);
      check_word("STATUS after six words", got, 32'd6);
      report_test("stream correctness", errs);
   endtask

   task automatic test_backpressure();
      int        errs;
      rng_word_t got;
      rng_word_t exp;
      ptr_t      wptr_full;
      errs = err_count;
      wb_write(RegCtrl, 32'h1);
      while (ptr_t'(gray_to_bin(async_wptr) - rd_ptr) != ptr_t'(Depth)) begin
         next_cycle();
      end
      wptr_full = async_wptr;
      wb_read(RegStatus, got);
      check_word("STATUS when full", got, {15'd0, 1'b1, 16'd10});
      check_bit("full flag", got[16], 1'b1);
      repeat (100) next_cycle();
      wb_read(RegStatus, got);
      check_word("STATUS after 100 stalled cycles", got, {15'd0, 1'b1, 16'd10});
      check_bit("write pointer held while full", async_wptr == wptr_full, 1'b1);
      for (int n = 0; n < Depth + 2; n++) begin
         pop_word(got);
         model_next_word(exp);
         check_word($sformatf("word %0d after stall", n), got, exp);
      end
      report_test("back-pressure", errs);
   endtask

   task automatic test_reseed();
      int        errs;
      rng_word_t got;
      rng_word_t exp;
      rng_word_t old_next;
      lfsr_t     new_seed;
      errs = err_count;
      wb_write(RegCtrl, 32'h0);
      repeat (2) next_cycle();
      // Words already queued belong to the old stream
      while (gray_to_bin(async_wptr) != rd_ptr) begin
         pop_word(got);
         model_next_word(exp);
         check_word("drained word", got, exp);
      end
      model_next_word(old_next);
      new_seed = lfsr_t'($urandom);
      if (new_seed == cur_seed) begin
         new_seed = new_seed ^ 16'h0001;
      end
      cur_seed = new_seed;
      wb_write(RegSeed, rng_word_t'(cur_seed));
      wb_read(RegSeed, got);
      check_seed("new SEED readback", got[15:0], cur_seed);
      model_load(cur_seed);
      wb_write(RegCtrl, 32'h1);
      for (int n = 0; n < 6; n++) begin
         pop_word(got);
         model_next_word(exp);
         check_word($sformatf("reseeded word %0d", n), got, exp);
         if (n == 0) begin
            check_bit("first word left the old stream", got != old_next, 1'b1);
         end
      end
      report_test("reseed", errs);
   endtask

   initial begin
      void'($urandom(RandSeed));
      rst_n      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_wdata   = '0;
      async_rptr = '0;
      rd_ptr     = '0;
      repeat (3) @(posedge clk);
      #(DriveDly);
      rst_n = 1'b1;
      // Internal reset releases two edges later
      repeat (3) next_cycle();
      test_reset();
      test_registers();
      test_stream();
      test_backpressure();
      test_reseed();
      $display("%0d checks, %0d errors", check_count, err_count);
      if (err_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: word_packer.sv
/*
 * Width converter from NumStreams entropy bits per step to 32-bit words
 */

`timescale 1ns/1ps

module word_packer
   import secsub_pkg::*;
#(
   parameter int unsigned NumStreams = 4
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  enable_i,
   input  logic                  restart_i,
   input  logic [NumStreams-1:0] bits_i,
   input  logic                  full_i,
   output logic                  step_o,
   output logic                  push_o,
   output rng_word_t             push_word_o
);

   localparam int unsigned Slots = $bits(rng_word_t) / NumStreams;
   localparam int unsigned SlotW = (Slots > 1) ? $clog2(Slots) : 1;

   logic [SlotW-1:0] slot_q;
   rng_word_t        word_q;
   logic             last_slot;

   assign last_slot = (slot_q == SlotW'(Slots - 1));

   // Hold the cells while a finished word has nowhere to go
   assign step_o = enable_i && !restart_i && !(last_slot && full_i);
   assign push_o = step_o && last_slot;

   // Top slot comes straight from the cells
   always_comb begin
      push_word_o = word_q;
      push_word_o[(Slots - 1) * NumStreams +: NumStreams] = bits_i;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         slot_q <= '0;
      end else if (restart_i) begin
         slot_q <= '0;
      end else if (step_o) begin
         slot_q <= last_slot ? '0 : slot_q + SlotW'(1);
      end
   end

   // Word under assembly, one slot per step
   always_ff @(posedge clk_i) begin
      if (step_o) begin
         word_q[slot_q * NumStreams +: NumStreams] <= bits_i;
      end
   end

endmodule
